// File: hdl/alu_pkg.sv
`default_nettype none

package alu_pkg;

    // default data width, a multiple of 8 for the byte reverse
    parameter int XLEN_DEF = 32;

    // bits examined per cycle by the bit counter, must divide the data width
    parameter int CNT_STEP_DEF = 8;

    // width of the counting cycle counter
    parameter int CNT_BITS = 6;

    // compare flags that go with every result
    parameter int FLAG_W   = 3;
    parameter int FLAG_EQ  = 0;
    parameter int FLAG_LT  = 1;
    parameter int FLAG_LTU = 2;

    typedef enum logic [4:0] {
        ALU_AND    = 5'd0,
        ALU_OR     = 5'd1,
        ALU_XOR    = 5'd2,
        ALU_SLL    = 5'd3,
        ALU_SRL    = 5'd4,
        ALU_SRA    = 5'd5,
        ALU_SLT    = 5'd6,
        ALU_SLTU   = 5'd7,
        ALU_ADD    = 5'd8,
        ALU_SUB    = 5'd9,
        ALU_MUL    = 5'd10,
        ALU_MULH   = 5'd11,
        ALU_DIV    = 5'd12,
        ALU_DIVU   = 5'd13,
        ALU_REM    = 5'd14,
        ALU_REMU   = 5'd15,
        ALU_PACK   = 5'd16,
        ALU_REV8   = 5'd17,
        ALU_SH1ADD = 5'd18,
        ALU_CPOP   = 5'd19,
        ALU_CTZ    = 5'd20
    } alu_op_e;

endpackage

`default_nettype wire

// File: hdl/alu_issue_stage.sv
`default_nettype none

module alu_issue_stage #(
    parameter int XLEN = alu_pkg::XLEN_DEF
) (
    input  logic             clk_i,
    input  logic             rstn_i,

    input  logic             req_valid_i,
    input  alu_pkg::alu_op_e req_op_i,
    input  logic [XLEN-1:0]  req_src1_i,
    input  logic [XLEN-1:0]  req_src2_i,
    output logic             req_ready_o,

    input  logic             res_valid_i,
    input  logic             res_ready_i,

    output logic             op_valid_o,
    output alu_pkg::alu_op_e op_o,
    output logic [XLEN-1:0]  src1_o,
    output logic [XLEN-1:0]  src2_o
);

    logic             held_r;
    alu_pkg::alu_op_e op_r;
    logic [XLEN-1:0]  src1_r;
    logic [XLEN-1:0]  src2_r;
    logic             complete;
    logic             take;

    // held request finishes this cycle, so its slot can be refilled at once
    assign complete    = held_r && res_valid_i && res_ready_i;
    assign req_ready_o = !held_r || complete;
    assign take        = req_valid_i && req_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            held_r <= 1'b0;
        end else if (take) begin
            held_r <= 1'b1;
        end else if (complete) begin
            held_r <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            op_r   <= req_op_i;
            src1_r <= req_src1_i;
            src2_r <= req_src2_i;
        end
    end

    assign op_valid_o = held_r;
    assign op_o       = op_r;
    assign src1_o     = src1_r;
    assign src2_o     = src2_r;

endmodule

`default_nettype wire

// File: hdl/alu_divider.sv
`default_nettype none

module alu_divider #(
    parameter int XLEN = alu_pkg::XLEN_DEF
) (
    input  logic            clk_i,
    input  logic            rstn_i,

    input  logic            start_i,
    input  logic            signed_i,
    input  logic            want_rem_i,
    input  logic [XLEN-1:0] dividend_i,
    input  logic [XLEN-1:0] divisor_i,

    input  logic            ack_i,
    output logic            done_o,
    output logic [XLEN-1:0] result_o
);

    localparam int STEP_W = $clog2(XLEN + 1);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_RUN  = 2'd1;
    localparam logic [1:0] ST_FIX  = 2'd2;
    localparam logic [1:0] ST_DONE = 2'd3;

    logic [1:0]        state_r;
    logic [STEP_W-1:0] step_r;
    logic [XLEN-1:0]   quo_r;
    logic [XLEN-1:0]   rem_r;
    logic [XLEN-1:0]   div_r;
    logic [XLEN-1:0]   result_r;
    logic              neg_quo_r;
    logic              neg_rem_r;
    logic              want_rem_r;
    logic [XLEN-1:0]   abs_dividend;
    logic [XLEN-1:0]   abs_divisor;
    logic [XLEN+1:0]   trial;

    assign abs_dividend = (signed_i && dividend_i[XLEN-1]) ? -dividend_i : dividend_i;
    assign abs_divisor  = (signed_i && divisor_i[XLEN-1]) ? -divisor_i : divisor_i;

    // shift in the next dividend bit and try the subtraction, top bit is the borrow
    assign trial = {1'b0, rem_r, quo_r[XLEN-1]} - {2'b00, div_r};

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_r <= ST_IDLE;
            step_r  <= '0;
        end else begin
            case (state_r)
                ST_IDLE: begin
                    step_r <= '0;
                    if (start_i) begin
                        state_r <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    step_r <= step_r + STEP_W'(1);
                    if (step_r == STEP_W'(XLEN - 1)) begin
                        state_r <= ST_FIX;
                    end
                end
                ST_FIX:  state_r <= ST_DONE;
                default: begin
                    if (ack_i) begin
                        state_r <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_r == ST_IDLE && start_i) begin
            quo_r      <= abs_dividend;
            rem_r      <= '0;
            div_r      <= abs_divisor;
            neg_quo_r  <= signed_i && (dividend_i[XLEN-1] ^ divisor_i[XLEN-1]);
            neg_rem_r  <= signed_i && dividend_i[XLEN-1];
            want_rem_r <= want_rem_i;
        end else if (state_r == ST_RUN) begin
            if (trial[XLEN+1]) begin
                rem_r <= {rem_r[XLEN-2:0], quo_r[XLEN-1]};
            end else begin
                rem_r <= trial[XLEN-1:0];
            end
            quo_r <= {quo_r[XLEN-2:0], !trial[XLEN+1]};
        end else if (state_r == ST_FIX) begin
            // most negative by -1 lands here with equal signs, so quotient
            // stays the dividend and remainder is 0
            if (want_rem_r) begin
                result_r <= neg_rem_r ? -rem_r : rem_r;
            end else begin
                result_r <= neg_quo_r ? -quo_r : quo_r;
            end
        end
    end

    assign done_o   = state_r == ST_DONE;
    assign result_o = result_r;

endmodule

`default_nettype wire

// File: hdl/alu_core.sv
`default_nettype none

module alu_core #(
    parameter int XLEN     = alu_pkg::XLEN_DEF,
    parameter int CNT_STEP = alu_pkg::CNT_STEP_DEF
) (
    input  logic                         clk_i,
    input  logic                         rstn_i,

    input  alu_pkg::alu_op_e             op_i,
    input  logic                         op_valid_i,
    input  logic [XLEN-1:0]              src1_i,
    input  logic [XLEN-1:0]              src2_i,

    input  logic                         res_ready_i,
    output logic                         res_valid_o,
    output logic [XLEN-1:0]              res_data_o,
    output logic [alu_pkg::FLAG_W-1:0]   res_flags_o
);

    import alu_pkg::*;

    localparam int SHAMT_W = $clog2(XLEN);
    localparam int NSLICE  = XLEN / CNT_STEP;

    logic signed [2*XLEN-1:0] prod;
    logic                     eq;
    logic                     lt;
    logic                     ltu;

    logic [CNT_BITS-1:0]      cnt_r;
    logic [XLEN-1:0]          acc_r;
    logic                     ctz_found_r;
    logic                     is_cnt;
    logic                     cnt_last;
    logic [XLEN-1:0]          cnt_shift;
    logic [CNT_STEP-1:0]      slice;
    logic [XLEN-1:0]          slice_cnt;
    logic                     ctz_run;

    logic                     div_started_r;
    logic                     is_div;
    logic                     div_zero;
    logic                     div_start;
    logic                     div_done;
    logic [XLEN-1:0]          div_result;
    logic                     res_done;

    assign eq   = src1_i == src2_i;
    assign lt   = $signed(src1_i) < $signed(src2_i);
    assign ltu  = src1_i < src2_i;

    // one signed product feeds both MUL and MULH
    assign prod = $signed(src1_i) * $signed(src2_i);

    assign res_flags_o[FLAG_EQ]  = eq;
    assign res_flags_o[FLAG_LT]  = lt;
    assign res_flags_o[FLAG_LTU] = ltu;

    assign res_done = res_valid_o && res_ready_i;

    // bit counting, one slice per cycle selected by the cycle counter
    assign is_cnt    = (op_i == ALU_CPOP) || (op_i == ALU_CTZ);
    assign cnt_last  = cnt_r == CNT_BITS'(NSLICE);
    assign cnt_shift = src1_i >> (cnt_r * CNT_STEP);
    assign slice     = cnt_shift[CNT_STEP-1:0];

    always_comb begin
        slice_cnt = '0;
        // zeros only count until the first set bit of the whole word
        ctz_run   = !ctz_found_r;
        for (int i = 0; i < CNT_STEP; i++) begin
            if (op_i == ALU_CPOP) begin
                slice_cnt = slice_cnt + XLEN'(slice[i]);
            end else if (slice[i]) begin
                ctz_run = 1'b0;
            end else if (ctz_run) begin
                slice_cnt = slice_cnt + XLEN'(1);
            end
        end
    end

    assign is_div    = (op_i == ALU_DIV) || (op_i == ALU_DIVU) ||
                       (op_i == ALU_REM) || (op_i == ALU_REMU);
    assign div_zero  = src2_i == '0;
    assign div_start = op_valid_i && is_div && !div_zero && !div_started_r;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            cnt_r         <= '0;
            acc_r         <= '0;
            ctz_found_r   <= 1'b0;
            div_started_r <= 1'b0;
        end else if (res_done || !op_valid_i) begin
            cnt_r         <= '0;
            acc_r         <= '0;
            ctz_found_r   <= 1'b0;
            div_started_r <= 1'b0;
        end else begin
            // stop at the last slice and hold while the result waits
            if (is_cnt && !cnt_last) begin
                cnt_r       <= cnt_r + CNT_BITS'(1);
                acc_r       <= acc_r + slice_cnt;
                ctz_found_r <= ctz_found_r || (|slice);
            end
            if (div_start) begin
                div_started_r <= 1'b1;
            end
        end
    end

    always_comb begin
        res_valid_o = op_valid_i;
        res_data_o  = '0;
        case (op_i)
            ALU_AND:    res_data_o = src1_i & src2_i;
            ALU_OR:     res_data_o = src1_i | src2_i;
            ALU_XOR:    res_data_o = src1_i ^ src2_i;
            ALU_SLL:    res_data_o = src1_i << src2_i[SHAMT_W-1:0];
            ALU_SRL:    res_data_o = src1_i >> src2_i[SHAMT_W-1:0];
            ALU_SRA:    res_data_o = $signed(src1_i) >>> src2_i[SHAMT_W-1:0];
            ALU_SLT:    res_data_o = XLEN'(lt);
            ALU_SLTU:   res_data_o = XLEN'(ltu);
            ALU_ADD:    res_data_o = src1_i + src2_i;
            ALU_SUB:    res_data_o = src1_i - src2_i;
            ALU_MUL:    res_data_o = prod[XLEN-1:0];
            ALU_MULH:   res_data_o = prod[2*XLEN-1:XLEN];
            ALU_DIV, ALU_DIVU: begin
                if (div_zero) begin
                    res_data_o = '1;
                end else begin
                    res_data_o  = div_result;
                    res_valid_o = op_valid_i && div_done;
                end
            end
            ALU_REM, ALU_REMU: begin
                if (div_zero) begin
                    res_data_o = src1_i;
                end else begin
                    res_data_o  = div_result;
                    res_valid_o = op_valid_i && div_done;
                end
            end
            ALU_PACK:   res_data_o = {src2_i[XLEN/2-1:0], src1_i[XLEN/2-1:0]};
            ALU_REV8: begin
                for (int b = 0; b < XLEN / 8; b++) begin
                    res_data_o[8*b +: 8] = src1_i[XLEN-8-8*b +: 8];
                end
            end
            ALU_SH1ADD: res_data_o = {src1_i[XLEN-2:0], 1'b0} + src2_i;
            ALU_CPOP, ALU_CTZ: begin
                res_data_o  = acc_r;
                res_valid_o = op_valid_i && cnt_last;
            end
            default:    res_data_o = '0;
        endcase
    end

    alu_divider #(
        .XLEN (XLEN)
    ) divider_i (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .start_i    (div_start),
        .signed_i   ((op_i == ALU_DIV) || (op_i == ALU_REM)),
        .want_rem_i ((op_i == ALU_REM) || (op_i == ALU_REMU)),
        .dividend_i (src1_i),
        .divisor_i  (src2_i),
        .ack_i      (res_done),
        .done_o     (div_done),
        .result_o   (div_result)
    );

endmodule

`default_nettype wire

// File: hdl/alu_result_fifo.sv
`default_nettype none

module alu_result_fifo #(
    parameter int XLEN = alu_pkg::XLEN_DEF
) (
    input  logic                       clk_i,
    input  logic                       rstn_i,

    input  logic                       in_valid_i,
    input  logic [XLEN-1:0]            in_data_i,
    input  logic [alu_pkg::FLAG_W-1:0] in_flags_i,
    output logic                       in_ready_o,

    output logic                       out_valid_o,
    output logic [XLEN-1:0]            out_data_o,
    output logic [alu_pkg::FLAG_W-1:0] out_flags_o,
    input  logic                       out_ready_i
);

    import alu_pkg::*;

    logic [XLEN-1:0]   mem_data  [2];
    logic [FLAG_W-1:0] mem_flags [2];
    logic              wr_ptr_r;
    logic              rd_ptr_r;
    logic [1:0]        count_r;
    logic              do_wr;
    logic              do_rd;

    assign out_valid_o = count_r != 2'd0;
    // a read in the same cycle frees a slot when full
    assign in_ready_o  = (count_r != 2'd2) || out_ready_i;
    assign do_wr       = in_valid_i && in_ready_o;
    assign do_rd       = out_valid_o && out_ready_i;

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem_data[wr_ptr_r]  <= in_data_i;
            mem_flags[wr_ptr_r] <= in_flags_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr_r <= 1'b0;
            rd_ptr_r <= 1'b0;
            count_r  <= 2'd0;
        end else begin
            if (do_wr) begin
                wr_ptr_r <= !wr_ptr_r;
            end
            if (do_rd) begin
                rd_ptr_r <= !rd_ptr_r;
            end
            if (do_wr && !do_rd) begin
                count_r <= count_r + 2'd1;
            end else if (do_rd && !do_wr) begin
                count_r <= count_r - 2'd1;
            end
        end
    end

    assign out_data_o  = mem_data[rd_ptr_r];
    assign out_flags_o = mem_flags[rd_ptr_r];

endmodule

`default_nettype wire

// File: hdl/alu_top.sv
`default_nettype none

module alu_top #(
    parameter int XLEN     = alu_pkg::XLEN_DEF,
    parameter int CNT_STEP = alu_pkg::CNT_STEP_DEF
) (
    input  logic                       clk_i,
    input  logic                       rstn_i,

    input  logic                       req_valid_i,
    input  alu_pkg::alu_op_e           req_op_i,
    input  logic [XLEN-1:0]            req_src1_i,
    input  logic [XLEN-1:0]            req_src2_i,
    output logic                       req_ready_o,

    output logic                       rsp_valid_o,
    output logic [XLEN-1:0]            rsp_data_o,
    output logic [alu_pkg::FLAG_W-1:0] rsp_flags_o,
    input  logic                       rsp_ready_i
);

    import alu_pkg::*;

    logic              op_valid;
    alu_op_e           op;
    logic [XLEN-1:0]   src1;
    logic [XLEN-1:0]   src2;
    logic              res_valid;
    logic [XLEN-1:0]   res_data;
    logic [FLAG_W-1:0] res_flags;
    logic              res_ready;

    alu_issue_stage #(
        .XLEN (XLEN)
    ) issue_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_valid_i (req_valid_i),
        .req_op_i    (req_op_i),
        .req_src1_i  (req_src1_i),
        .req_src2_i  (req_src2_i),
        .req_ready_o (req_ready_o),
        .res_valid_i (res_valid),
        .res_ready_i (res_ready),
        .op_valid_o  (op_valid),
        .op_o        (op),
        .src1_o      (src1),
        .src2_o      (src2)
    );

    alu_core #(
        .XLEN     (XLEN),
        .CNT_STEP (CNT_STEP)
    ) core_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .op_i        (op),
        .op_valid_i  (op_valid),
        .src1_i      (src1),
        .src2_i      (src2),
        .res_ready_i (res_ready),
        .res_valid_o (res_valid),
        .res_data_o  (res_data),
        .res_flags_o (res_flags)
    );

    alu_result_fifo #(
        .XLEN (XLEN)
    ) fifo_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .in_valid_i  (res_valid),
        .in_data_i   (res_data),
        .in_flags_i  (res_flags),
        .in_ready_o  (res_ready),
        .out_valid_o (rsp_valid_o),
        .out_data_o  (rsp_data_o),
        .out_flags_o (rsp_flags_o),
        .out_ready_i (rsp_ready_i)
    );

endmodule

`default_nettype wire

// File: sim/alu_tb_model.svh
`ifndef ALU_TB_MODEL_SVH
`define ALU_TB_MODEL_SVH

// compare flags come from the two operands, whatever the operation
function automatic logic [FLAG_W-1:0] expected_flags(input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
    logic [FLAG_W-1:0] f;
    f[FLAG_EQ]  = a == b;
    f[FLAG_LT]  = $signed(a) < $signed(b);
    f[FLAG_LTU] = a < b;
    return f;
endfunction

function automatic logic [XLEN-1:0] expected_result(input alu_op_e op,
                                                    input logic [XLEN-1:0] a,
                                                    input logic [XLEN-1:0] b);
    logic signed [2*XLEN-1:0] wide;
    logic [XLEN-1:0]          most_neg;
    logic [XLEN-1:0]          r;
    int                       sh;
    most_neg = {1'b1, {(XLEN-1){1'b0}}};
    wide     = $signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{b[XLEN-1]}}, b});
    sh       = int'(b % XLEN);
    r        = '0;
    case (op)
        ALU_AND:    r = a & b;
        ALU_OR:     r = a | b;
        ALU_XOR:    r = a ^ b;
        ALU_SLL:    r = a << sh;
        ALU_SRL:    r = a >> sh;
        ALU_SRA:    r = $signed(a) >>> sh;
        ALU_SLT:    r = ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
        ALU_SLTU:   r = (a < b) ? XLEN'(1) : '0;
        ALU_ADD:    r = a + b;
        ALU_SUB:    r = a - b;
        ALU_MUL:    r = wide[XLEN-1:0];
        ALU_MULH:   r = wide[2*XLEN-1:XLEN];
        ALU_DIV: begin
            // RISC-V: divide by zero gives all ones, overflow gives the dividend
            if (b == '0) begin
                r = '1;
            end else if (a == most_neg && b == '1) begin
                r = a;
            end else begin
                r = $signed(a) / $signed(b);
            end
        end
        ALU_DIVU:   r = (b == '0) ? '1 : a / b;
        ALU_REM: begin
            if (b == '0) begin
                r = a;
            end else if (a == most_neg && b == '1) begin
                r = '0;
            end else begin
                r = $signed(a) % $signed(b);
            end
        end
        ALU_REMU:   r = (b == '0) ? a : a % b;
        ALU_PACK:   r = {b[XLEN/2-1:0], a[XLEN/2-1:0]};
        ALU_REV8: begin
            for (int i = 0; i < XLEN / 8; i++) begin
                r[8*i +: 8] = a[XLEN-1-8*i -: 8];
            end
        end
        ALU_SH1ADD: r = (a << 1) + b;
        ALU_CPOP: begin
            for (int i = 0; i < XLEN; i++) begin
                r = r + XLEN'(a[i]);
            end
        end
        ALU_CTZ: begin
            // scan down so the lowest set bit wins, zero input keeps XLEN
            r = XLEN;
            for (int i = XLEN - 1; i >= 0; i--) begin
                if (a[i]) begin
                    r = i;
                end
            end
        end
        default:    r = '0;
    endcase
    return r;
endfunction

`endif

// File: sim/alu_tb.sv
`default_nettype none

module alu_tb;

    import alu_pkg::*;

    localparam int XLEN          = XLEN_DEF;
    localparam int SEED          = 32'h0c52_aff3;
    localparam int REQ_TIMEOUT   = 200;
    localparam int DRAIN_TIMEOUT = 4000;
    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

    `include "alu_tb_model.svh"

    logic              clk;
    logic              rstn;
    logic              req_valid;
    alu_op_e           req_op;
    logic [XLEN-1:0]   req_src1;
    logic [XLEN-1:0]   req_src2;
    logic              req_ready;
    logic              rsp_valid;
    logic [XLEN-1:0]   rsp_data;
    logic [FLAG_W-1:0] rsp_flags;
    logic              rsp_ready;

    // expected responses in request order, head mirrored into plain signals
    logic [FLAG_W+XLEN-1:0] exp_q [$];
    logic                   exp_avail = 1'b0;
    logic [XLEN-1:0]        exp_data  = '0;
    logic [FLAG_W-1:0]      exp_flags = '0;

    int      seed;
    int      bp_seed;
    int      bp_left;
    logic    bp_on;
    logic    b2b_on;
    alu_op_e single_ops [15] = '{ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
                                 ALU_SLT, ALU_SLTU, ALU_ADD, ALU_SUB, ALU_MUL, ALU_MULH,
                                 ALU_PACK, ALU_REV8, ALU_SH1ADD};

    alu_top dut_i (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .req_valid_i (req_valid),
        .req_op_i    (req_op),
        .req_src1_i  (req_src1),
        .req_src2_i  (req_src2),
        .req_ready_o (req_ready),
        .rsp_valid_o (rsp_valid),
        .rsp_data_o  (rsp_data),
        .rsp_flags_o (rsp_flags),
        .rsp_ready_i (rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        if (!rstn) begin
            exp_q.delete();
        end else begin
            if (rsp_valid && rsp_ready && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
            if (req_valid && req_ready) begin
                exp_q.push_back({expected_flags(req_src1, req_src2),
                                 expected_result(req_op, req_src1, req_src2)});
            end
        end
        exp_avail = exp_q.size() > 0;
        if (exp_avail) begin
            {exp_flags, exp_data} = exp_q[0];
        end
    end

    // consumer ready, random stretches high and low while back-pressure is on
    always @(posedge clk) begin
        if (!bp_on) begin
            rsp_ready <= 1'b1;
        end else if (bp_left == 0) begin
            rsp_ready <= ({$random(bp_seed)} % 2) == 0;
            bp_left = {$random(bp_seed)} % 6;
        end else begin
            bp_left = bp_left - 1;
        end
    end

    a_reset_valid: assert property (@(posedge clk) $rose(rstn) |-> !rsp_valid)
        else report_failure($sformatf("mismatch rsp_valid_o: got %h expected 0",
                                      $sampled(rsp_valid)));
    a_reset_ready: assert property (@(posedge clk) $rose(rstn) |-> req_ready)
        else report_failure($sformatf("mismatch req_ready_o: got %h expected 1",
                                      $sampled(req_ready)));
    a_no_extra: assert property (@(posedge clk) disable iff (!rstn)
        (rsp_valid && rsp_ready) |-> exp_avail)
        else report_failure("a response arrived with no request pending");
    a_data: assert property (@(posedge clk) disable iff (!rstn)
        (rsp_valid && rsp_ready) |-> rsp_data == exp_data)
        else report_failure($sformatf("mismatch rsp_data_o: got %h expected %h",
                                      $sampled(rsp_data), $sampled(exp_data)));
    a_flags: assert property (@(posedge clk) disable iff (!rstn)
        (rsp_valid && rsp_ready) |-> rsp_flags == exp_flags)
        else report_failure($sformatf("mismatch rsp_flags_o: got %h expected %h",
                                      $sampled(rsp_flags), $sampled(exp_flags)));
    a_hold_valid: assert property (@(posedge clk) disable iff (!rstn)
        (rsp_valid && !rsp_ready) |=> rsp_valid)
        else report_failure("rsp_valid_o dropped before the response was taken");
    a_hold_data: assert property (@(posedge clk) disable iff (!rstn)
        (rsp_valid && !rsp_ready) |=> $stable(rsp_data))
        else report_failure($sformatf("mismatch rsp_data_o while stalled: got %h expected %h",
                                      $sampled(rsp_data), $sampled(exp_data)));
    a_hold_flags: assert property (@(posedge clk) disable iff (!rstn)
        (rsp_valid && !rsp_ready) |=> $stable(rsp_flags))
        else report_failure($sformatf("mismatch rsp_flags_o while stalled: got %h expected %h",
                                      $sampled(rsp_flags), $sampled(exp_flags)));
    a_b2b_ready: assert property (@(posedge clk) disable iff (!rstn)
        (b2b_on && req_valid) |-> req_ready)
        else report_failure("req_ready_o dropped during a back-to-back burst");
    a_b2b_rsp: assert property (@(posedge clk) disable iff (!rstn)
        (b2b_on && req_valid && req_ready) |-> ##2 (rsp_valid && rsp_ready))
        else report_failure("back-to-back response missing two cycles after its request");

    task automatic send_req(input alu_op_e op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b);
        int waited;
        waited = 0;
        req_valid <= 1'b1;
        req_op    <= op;
        req_src1  <= a;
        req_src2  <= b;
        @(posedge clk);
        while (!req_ready) begin
            waited++;
            if (waited > REQ_TIMEOUT) begin
                report_failure("request was not accepted within the timeout");
            end
            @(posedge clk);
        end
        req_valid <= 1'b0;
    endtask

    task automatic send_random_single();
        alu_op_e         op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        op = single_ops[{$random(seed)} % 15];
        a  = $random(seed);
        // equal operands now and then so the eq flag gets set
        b  = ({$random(seed)} % 8 == 0) ? a : $random(seed);
        send_req(op, a, b);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                report_failure("pending responses did not arrive within the timeout");
            end
        end
    endtask

    initial begin
        alu_op_e         op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        seed      = SEED;
        bp_seed   = SEED + 1;
        bp_left   = 0;
        bp_on     = 1'b0;
        b2b_on    = 1'b0;
        rstn      = 1'b0;
        req_valid = 1'b0;
        req_op    = ALU_AND;
        req_src1  = '0;
        req_src2  = '0;
        rsp_ready = 1'b1;
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);

        repeat (80) send_random_single();
        wait_drain();

        // division with random, small and zero divisors
        for (int i = 0; i < 40; i++) begin
            op = alu_op_e'(ALU_DIV + ({$random(seed)} % 4));
            a  = $random(seed);
            case ({$random(seed)} % 4)
                0:       b = '0;
                1:       b = $random(seed) % 8;
                default: b = $random(seed);
            endcase
            send_req(op, a, b);
        end
        for (int k = 0; k < 4; k++) begin
            op = alu_op_e'(ALU_DIV + k);
            send_req(op, MOST_NEG, '1);
            send_req(op, $random(seed), '0);
        end
        wait_drain();

        // bit counting on corner values and single bits at byte edges
        for (int k = 0; k < 2; k++) begin
            op = (k == 0) ? ALU_CPOP : ALU_CTZ;
            send_req(op, '0, $random(seed));
            send_req(op, '1, $random(seed));
            for (int bit_i = 0; bit_i < XLEN; bit_i += 8) begin
                send_req(op, XLEN'(1) << bit_i, $random(seed));
                send_req(op, XLEN'(1) << (bit_i + 7), $random(seed));
            end
            repeat (10) send_req(op, $random(seed), $random(seed));
        end
        wait_drain();

        // every operation under random back-pressure
        bp_on <= 1'b1;
        repeat (80) begin
            op = alu_op_e'({$random(seed)} % 21);
            send_req(op, $random(seed), $random(seed));
        end
        wait_drain();
        bp_on <= 1'b0;
        repeat (2) @(posedge clk);

        b2b_on <= 1'b1;
        repeat (16) send_random_single();
        b2b_on <= 1'b0;
        wait_drain();
        repeat (4) @(posedge clk);

        if (rsp_valid || exp_q.size() != 0) begin
            report_failure("responses left over at the end of the test");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+sim
hdl/alu_pkg.sv
hdl/alu_issue_stage.sv
hdl/alu_divider.sv
hdl/alu_core.sv
hdl/alu_result_fifo.sv
hdl/alu_top.sv
sim/alu_tb.sv
